// ==== design/isaPkg.sv ====
package isaPkg;

	// One machine word holds both data and the PC.
	localparam int dataW = 16;
	localparam int regAddrW = 3; // Eight architectural registers.

	// Shifts only look at enough low bits to cover one word.
	localparam int shamtW = $clog2(dataW);

	typedef enum logic [3:0] {
		add   = 4'd0,
		sub   = 4'd1,
		andOp = 4'd2,
		orOp  = 4'd3,
		xorOp = 4'd4,
		sll   = 4'd5,
		srl   = 4'd6,
		slt   = 4'd7, // Signed compare, result is 0 or 1.
		passB = 4'd8
	} aluOpE;

	// Conditions compare the two register operands.
	// The unconditional case also covers jump-and-link.
	typedef enum logic [2:0] {
		none        = 3'd0,
		eq          = 3'd1,
		ne          = 3'd2,
		lt          = 3'd3,
		alwaysTaken = 3'd4
	} brCondE;

endpackage

// ==== design/pipePkg.sv ====
package pipePkg;
	import isaPkg::*;

	// One decoded operation as it leaves the issue stage.
	typedef struct packed {
		logic [dataW-1:0]    opA;
		logic [dataW-1:0]    opB;
		logic [dataW-1:0]    imm;
		logic [dataW-1:0]    pc;
		logic                useImm;
		aluOpE               aluOp;
		brCondE              brCond;
		logic                regWrite;
		logic                memEn;
		logic                memWrite;
		logic                memToReg;
		logic                link;
		logic [regAddrW-1:0] dest;
	} issueBundleT;

	typedef struct packed {
		logic [dataW-1:0]    aluResult; // Also the memory address.
		logic [dataW-1:0]    storeData;
		logic [dataW-1:0]    linkPc;
		logic [dataW-1:0]    branchTarget;
		logic                takeBranch;
		logic                regWrite;
		logic                memEn;
		logic                memWrite;
		logic                memToReg;
		logic                link;
		logic [regAddrW-1:0] dest;
	} exMemBundleT;

	typedef struct packed {
		logic [dataW-1:0]    aluResult;
		logic [dataW-1:0]    loadData;
		logic [dataW-1:0]    linkPc;
		logic                regWrite;
		logic                memToReg;
		logic                link;
		logic [regAddrW-1:0] dest;
	} memWbBundleT;

	// Register file write port.
	typedef struct packed {
		logic                valid;
		logic [regAddrW-1:0] addr;
		logic [dataW-1:0]    data;
	} regWriteT;

endpackage

// ==== design/executeStage.sv ====
`timescale 1ns/1ns

module executeStage
	import isaPkg::*, pipePkg::*;
(
	input  issueBundleT issue,
	output exMemBundleT exOut
);

	logic [dataW-1:0] aluB;
	logic [dataW-1:0] aluResult;
	logic [dataW-1:0] nextPc;
	logic [shamtW-1:0] shamt;
	logic takeBranch;

	assign aluB = issue.useImm ? issue.imm : issue.opB;
	assign shamt = aluB[shamtW-1:0];
	assign nextPc = issue.pc + 1'b1;

	always_comb begin
		case (issue.aluOp)
			add: begin
				aluResult = issue.opA + aluB;
			end
			sub: begin
				aluResult = issue.opA - aluB;
			end
			andOp: begin
				aluResult = issue.opA & aluB;
			end
			orOp: begin
				aluResult = issue.opA | aluB;
			end
			xorOp: begin
				aluResult = issue.opA ^ aluB;
			end
			sll: begin
				aluResult = issue.opA << shamt;
			end
			srl: begin
				aluResult = issue.opA >> shamt; // Logical, zeros shift in.
			end
			slt: begin
				aluResult = {{(dataW-1){1'b0}}, $signed(issue.opA) < $signed(aluB)};
			end
			passB: begin
				aluResult = aluB;
			end
			default: begin
				aluResult = '0;
			end
		endcase
	end

	// Branches always compare the register operands, never the immediate.
	always_comb begin
		case (issue.brCond)
			eq: begin
				takeBranch = (issue.opA == issue.opB);
			end
			ne: begin
				takeBranch = (issue.opA != issue.opB);
			end
			lt: begin
				takeBranch = ($signed(issue.opA) < $signed(issue.opB));
			end
			alwaysTaken: begin
				takeBranch = 1'b1;
			end
			default: begin
				takeBranch = 1'b0;
			end
		endcase
	end

	always_comb begin
		exOut.aluResult = aluResult;
		exOut.storeData = issue.opB;
		exOut.linkPc = nextPc;
		exOut.branchTarget = nextPc + issue.imm; // Target is relative to the next PC.
		exOut.takeBranch = takeBranch;
		exOut.regWrite = issue.regWrite;
		exOut.memEn = issue.memEn;
		exOut.memWrite = issue.memWrite;
		exOut.memToReg = issue.memToReg;
		exOut.link = issue.link;
		exOut.dest = issue.dest;
	end

endmodule

// ==== design/exMemLatch.sv ====
`timescale 1ns/1ns

module exMemLatch
	import pipePkg::*;
(
	input  logic        clk,
	input  logic        arstN,
	input  logic        en,
	input  exMemBundleT exIn,
	output exMemBundleT memIn
);

	exMemBundleT held;

	// The whole bundle advances on en and sits still otherwise.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			held <= '0;
		end else if (en) begin
			held <= exIn;
		end
	end

	// A stalled operation is shown to the memory stage as a no-op.
	// When en comes back the same operation is presented again with
	// its controls intact, so it acts exactly once.
	always_comb begin
		memIn = held;
		if (!en) begin
			memIn.regWrite = 1'b0;
			memIn.memEn = 1'b0;
			memIn.memWrite = 1'b0;
			memIn.takeBranch = 1'b0; // Keeps a redirect from firing during the stall.
		end
	end

endmodule

// ==== design/memoryStage.sv ====
`timescale 1ns/1ns

module memoryStage
	import isaPkg::*, pipePkg::*;
#(
	parameter int unsigned memWords = 256
)(
	input  logic             clk,
	input  exMemBundleT      memIn,
	output memWbBundleT      wbIn,
	output logic             redirect,
	output logic [dataW-1:0] redirectPc
);

	localparam int addrW = (memWords > 1) ? $clog2(memWords) : 1;

	logic [dataW-1:0] dataMem [memWords];
	logic [addrW-1:0] wordAddr;
	logic storeEn;

	// Addresses past the end of memory wrap around.
	assign wordAddr = addrW'(memIn.aluResult % memWords);
	assign storeEn = memIn.memEn && memIn.memWrite;

	always_ff @(posedge clk) begin
		if (storeEn) begin
			dataMem[wordAddr] <= memIn.storeData;
		end
	end

	always_comb begin
		wbIn.aluResult = memIn.aluResult;
		wbIn.loadData = dataMem[wordAddr]; // Read is combinational.
		wbIn.linkPc = memIn.linkPc;
		wbIn.regWrite = memIn.regWrite;
		wbIn.memToReg = memIn.memToReg;
		wbIn.link = memIn.link;
		wbIn.dest = memIn.dest;
	end

	// The branch is resolved in execute and acted on here, one cycle after issue.
	assign redirect = memIn.takeBranch;
	assign redirectPc = memIn.branchTarget;

endmodule

// ==== design/writebackStage.sv ====
`timescale 1ns/1ns

module writebackStage
	import isaPkg::*, pipePkg::*;
(
	input  logic        clk,
	input  logic        arstN,
	input  logic        en,
	input  memWbBundleT wbIn,
	output regWriteT    wb
);

	memWbBundleT wbReg;
	logic [dataW-1:0] wbData;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wbReg <= '0;
		end else if (en) begin
			wbReg <= wbIn;
		end else begin
			// Bubble, so the op held upstream is written only once.
			wbReg.regWrite <= 1'b0;
		end
	end

	// Link wins over a load, a load wins over the ALU result.
	always_comb begin
		if (wbReg.link) begin
			wbData = wbReg.linkPc;
		end else if (wbReg.memToReg) begin
			wbData = wbReg.loadData;
		end else begin
			wbData = wbReg.aluResult;
		end
	end

	always_comb begin
		wb.valid = wbReg.regWrite;
		wb.addr = wbReg.dest;
		wb.data = wbData;
	end

endmodule

// ==== design/execBackEnd.sv ====
`timescale 1ns/1ns

module execBackEnd
	import isaPkg::*, pipePkg::*;
#(
	parameter int unsigned memWords = 256
)(
	input  logic             clk,
	input  logic             arstN,
	input  logic             en,
	input  issueBundleT      issue,
	output regWriteT         wb,
	output logic             redirect,
	output logic [dataW-1:0] redirectPc
);

	exMemBundleT exOut;
	exMemBundleT memIn;
	memWbBundleT wbIn;

	executeStage execute (
		.issue(issue),
		.exOut(exOut)
	);

	exMemLatch exMem (
		.clk(clk),
		.arstN(arstN),
		.en(en),
		.exIn(exOut),
		.memIn(memIn)
	);

	memoryStage #(
		.memWords(memWords)
	) memory (
		.clk(clk),
		.memIn(memIn),
		.wbIn(wbIn),
		.redirect(redirect),
		.redirectPc(redirectPc)
	);

	writebackStage writeback (
		.clk(clk),
		.arstN(arstN),
		.en(en),
		.wbIn(wbIn),
		.wb(wb)
	);

endmodule

// ==== sim/execBackEndTb.sv ====
`timescale 1ns/1ns

module execBackEndTb
	import isaPkg::*, pipePkg::*;
();

	localparam int clkPeriod = 100;
	localparam int memWords = 256;
	localparam int resetCycles = 10;
	localparam int idleCycles = 6;
	localparam int nAluOps = 200;
	localparam int nMemPairs = 24;
	localparam int nBranches = 60;
	localparam int nStallOps = 80;
	localparam int maxStall = 3;
	localparam int marginCycles = 60;

	// Every stalled op can cost itself plus the longest stall.
	localparam int runCycles = resetCycles + idleCycles + nAluOps + 3 * nMemPairs + nBranches
		+ nStallOps * (1 + maxStall) + marginCycles;

	// Expected outcome of one issued operation.
	typedef struct packed {
		logic                write;
		logic [regAddrW-1:0] dest;
		logic [dataW-1:0]    data;
		logic [dataW-1:0]    alu; // Doubles as the memory address.
		logic                take;
		logic [dataW-1:0]    target;
	} expectT;

	logic clk;
	logic arstN;
	logic en;
	issueBundleT issue;
	regWriteT wb;
	logic redirect;
	logic [dataW-1:0] redirectPc;

	expectT issueExp; // Prediction for the op on the issue bus.
	expectT latchExp; // Shadow of the EX/MEM latch.
	expectT wbExp;    // Shadow of the MEM/WB register.
	expectT expQ[$];
	logic [dataW-1:0] modelMem [memWords];
	logic [dataW-1:0] lastAddr;
	int errors;
	int checks;

	execBackEnd #(
		.memWords(memWords)
	) DUT (
		.clk(clk),
		.arstN(arstN),
		.en(en),
		.issue(issue),
		.wb(wb),
		.redirect(redirect),
		.redirectPc(redirectPc)
	);

	initial clk = 1'b0;
	always #(clkPeriod / 2) clk = ~clk;

	task automatic checkValue(input string name, input logic [dataW-1:0] expected,
			input logic [dataW-1:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic reportFailure(input string what);
		errors++;
		$display("ERROR at %0t ns: %s", $time, what);
	endtask

	// Reference model of one operation, written from the ISA rules.
	function automatic expectT predict(issueBundleT op);
		logic [dataW-1:0] b;
		logic [dataW-1:0] nextPc;
		expectT e;
		e = '0;
		b = op.useImm ? op.imm : op.opB;
		nextPc = op.pc + dataW'(1);
		if (op.aluOp == add) e.alu = op.opA + b;
		else if (op.aluOp == sub) e.alu = op.opA - b;
		else if (op.aluOp == andOp) e.alu = op.opA & b;
		else if (op.aluOp == orOp) e.alu = op.opA | b;
		else if (op.aluOp == xorOp) e.alu = op.opA ^ b;
		else if (op.aluOp == sll) e.alu = op.opA << (b % 16);
		else if (op.aluOp == srl) e.alu = op.opA >> (b % 16);
		else if (op.aluOp == slt) e.alu = ($signed(op.opA) < $signed(b)) ? dataW'(1) : '0;
		else if (op.aluOp == passB) e.alu = b;
		e.write = op.regWrite;
		e.dest = op.dest;
		if (op.link) begin
			e.data = nextPc;
		end else if (op.memToReg) begin
			e.data = modelMem[e.alu % memWords];
		end else begin
			e.data = e.alu;
		end
		case (op.brCond)
			eq: e.take = (op.opA == op.opB);
			ne: e.take = (op.opA != op.opB);
			lt: e.take = ($signed(op.opA) < $signed(op.opB));
			alwaysTaken: e.take = 1'b1;
			default: e.take = 1'b0;
		endcase
		e.target = nextPc + op.imm;
		return e;
	endfunction

	function automatic issueBundleT bubbleOp();
		issueBundleT op;
		op = '0;
		return op;
	endfunction

	function automatic issueBundleT aluOpFor(aluOpE kind);
		issueBundleT op;
		op = '0;
		op.opA = dataW'($urandom);
		op.opB = dataW'($urandom);
		op.imm = dataW'($urandom);
		op.pc = dataW'($urandom);
		op.useImm = 1'($urandom_range(0, 1));
		op.aluOp = kind;
		op.regWrite = 1'b1;
		op.dest = regAddrW'($urandom);
		return op;
	endfunction

	function automatic issueBundleT storeOp(logic [dataW-1:0] addr, logic [dataW-1:0] data);
		issueBundleT op;
		op = '0;
		op.imm = dataW'($urandom_range(0, 63));
		op.opA = addr - op.imm;
		op.opB = data;
		op.pc = dataW'($urandom);
		op.useImm = 1'b1;
		op.aluOp = add;
		op.memEn = 1'b1;
		op.memWrite = 1'b1;
		return op;
	endfunction

	// Loads go through an alias a whole number of memory sizes away.
	function automatic issueBundleT loadOp(logic [dataW-1:0] addr, logic [regAddrW-1:0] dest);
		issueBundleT op;
		op = '0;
		op.imm = dataW'($urandom_range(0, 63));
		op.opA = addr + dataW'(memWords * $urandom_range(0, 7)) - op.imm;
		op.pc = dataW'($urandom);
		op.useImm = 1'b1;
		op.aluOp = add;
		op.memEn = 1'b1;
		op.memToReg = 1'b1;
		op.regWrite = 1'b1;
		op.dest = dest;
		return op;
	endfunction

	function automatic issueBundleT branchOp(brCondE cond, logic withLink);
		issueBundleT op;
		op = '0;
		op.opA = dataW'($urandom);
		op.opB = ($urandom_range(0, 2) == 0) ? op.opA : dataW'($urandom);
		op.imm = dataW'($urandom);
		op.pc = dataW'($urandom);
		op.brCond = cond;
		op.link = withLink;
		op.regWrite = withLink;
		op.dest = regAddrW'($urandom);
		return op;
	endfunction

	task automatic sendOp(input issueBundleT op);
		expectT e;
		e = predict(op);
		@(posedge clk);
		issue <= op;
		issueExp <= e;
		en <= 1'b1;
		if (op.regWrite) expQ.push_back(e);
		if (op.memEn && op.memWrite) modelMem[e.alu % memWords] = op.opB;
	endtask

	task automatic stallFor(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			en <= 1'b0;
		end
	endtask

	// Tracks where each op sits, following the en rules of both latches.
	always @(posedge clk) begin
		if (!arstN) begin
			latchExp <= '0;
			wbExp <= '0;
		end else if (en) begin
			wbExp <= latchExp;
			latchExp <= issueExp;
		end else begin
			wbExp.write <= 1'b0;
		end
	end

	always @(negedge clk) begin
		expectT head;
		if (arstN) begin
			checkValue("wb.valid", wbExp.write, wb.valid);
			if (wb.valid) begin
				if (expQ.size() == 0) begin
					reportFailure("register write arrived with no operation outstanding");
				end else begin
					head = expQ.pop_front();
					checkValue("wb.addr", head.dest, wb.addr);
					checkValue("wb.data", head.data, wb.data);
				end
			end
			checkValue("redirect", en && latchExp.take, redirect);
			if (en && latchExp.take && redirect) begin
				checkValue("redirectPc", latchExp.target, redirectPc);
			end
		end
	end

	initial begin
		issueBundleT op;
		int kind;
		int drain;
		void'($urandom(32'h86bf));
		errors = 0;
		checks = 0;
		arstN = 1'b0;
		en = 1'b0;
		issue = bubbleOp();
		issueExp = '0;
		lastAddr = '0;
		repeat (resetCycles) @(posedge clk);
		arstN <= 1'b1;

		repeat (idleCycles) sendOp(bubbleOp()); // Pipeline must stay quiet.

		for (int i = 0; i < nAluOps; i++) begin
			sendOp(aluOpFor(aluOpE'(i % 9)));
		end

		for (int i = 0; i < nMemPairs; i++) begin
			lastAddr = dataW'($urandom);
			sendOp(storeOp(lastAddr, dataW'($urandom)));
			sendOp(loadOp(lastAddr, regAddrW'($urandom)));
			if (i % 3 == 0) sendOp(storeOp(dataW'($urandom), dataW'($urandom)));
		end

		// Every fifth branch is unconditional, half of those link.
		for (int i = 0; i < nBranches; i++) begin
			sendOp(branchOp(brCondE'(i % 5), (i % 10) == 4));
		end

		for (int i = 0; i < nStallOps; i++) begin
			kind = $urandom_range(0, 3);
			case (kind)
				0: op = aluOpFor(aluOpE'($urandom_range(0, 8)));
				1: begin
					lastAddr = dataW'($urandom);
					op = storeOp(lastAddr, dataW'($urandom));
				end
				2: op = loadOp(lastAddr, regAddrW'($urandom));
				default: op = branchOp(brCondE'($urandom_range(0, 4)), 1'($urandom_range(0, 1)));
			endcase
			sendOp(op);
			if ($urandom_range(0, 1) == 1) stallFor($urandom_range(1, maxStall));
		end

		drain = 0;
		while (expQ.size() != 0 && drain < 8) begin
			sendOp(bubbleOp());
			drain++;
		end
		repeat (3) sendOp(bubbleOp()); // Catch any late extra write.
		@(negedge clk);
		if (expQ.size() != 0) begin
			reportFailure($sformatf("%0d register writes never arrived", expQ.size()));
		end

		$display("Run finished: %0d checks, %0d errors.", checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	initial begin
		#(runCycles * clkPeriod);
		$display("Watchdog expired after %0d cycles, the run did not complete.", runCycles);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== flist.f ====
design/isaPkg.sv
design/pipePkg.sv
design/executeStage.sv
design/exMemLatch.sv
design/memoryStage.sv
design/writebackStage.sv
design/execBackEnd.sv
sim/execBackEndTb.sv

// ==== Bender.yml ====
package:
  name: exec_back_end

sources:
  - target: any(rtl, test)
    files:
      - design/isaPkg.sv
      - design/pipePkg.sv
      - design/executeStage.sv
      - design/exMemLatch.sv
      - design/memoryStage.sv
      - design/writebackStage.sv
      - design/execBackEnd.sv
  - target: test
    files:
      - sim/execBackEndTb.sv
